/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = lc3b_frontend_tb
FILELIST = vlog.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_TEXT = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/lc3b_frontend_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_frontend_checker
    import lc3b_pkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input logic                  mem_request,
    input logic                  mem_resp,
    input logic [WORD_WIDTH-1:0] mem_addr,
    input logic                  redirect,
    input logic                  issue_valid
);

    int failures = 0;

    // only a redirect may move the address under a live request.
    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        mem_request && !mem_resp && !redirect |=> mem_request && $stable(mem_addr))
        else
        begin
            failures++;
            $error("mem_addr changed while mem_request was held");
        end

    a_issue_after_resp: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> $past(mem_request && mem_resp))
        else
        begin
            failures++;
            $error("issue_valid without an accepted response in the cycle before");
        end

    a_reset_idle: assert property (@(posedge clk)
        reset |=> !mem_request && !issue_valid)
        else
        begin
            failures++;
            $error("mem_request or issue_valid high after reset");
        end

endmodule

`default_nettype wire

/* test/lc3b_frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_frontend_tb
    import lc3b_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_INSTR = 300;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 40;

    logic                  clk;
    logic                  reset;
    logic                  mem_resp;
    logic [WORD_WIDTH-1:0] mem_rdata;
    logic                  issue_credit;
    logic                  redirect;
    logic [WORD_WIDTH-1:0] redirect_pc;
    logic                  mem_request;
    logic [WORD_WIDTH-1:0] mem_addr;
    logic                  issue_valid;
    logic [WORD_WIDTH-1:0] issue_pc;
    logic [WORD_WIDTH-1:0] imm5;
    logic [WORD_WIDTH-1:0] imm4;
    logic [WORD_WIDTH-1:0] offset6;
    logic [WORD_WIDTH-1:0] offset9;
    logic [WORD_WIDTH-1:0] offset11;
    logic [WORD_WIDTH-1:0] trapvect8;
    logic [CTRL_WIDTH-1:0] issue_ctrl;
    logic [REG_WIDTH-1:0]  dest;
    logic [REG_WIDTH-1:0]  src1;
    logic [REG_WIDTH-1:0]  src2;

    integer                seed;
    int                    held;
    int                    issued;
    int                    cycle;
    int                    mem_wait;
    int                    in_use;
    logic                  busy;
    logic                  discard;
    logic                  issue_due;
    logic                  accept;
    logic                  kept;
    logic [WORD_WIDTH-1:0] exp_pc;
    logic [WORD_WIDTH-1:0] req_addr;
    logic [WORD_WIDTH-1:0] due_addr;
    logic [31:0]           rnd;

    lc3b_frontend DUT (.*);

    bind lc3b_frontend lc3b_frontend_checker u_checker (
        .clk(clk), .reset(reset), .mem_request(mem_request), .mem_resp(mem_resp),
        .mem_addr(mem_addr), .redirect(redirect), .issue_valid(issue_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hashed contents, with every eighth word zero so the no-op path is hit.
    function automatic logic [WORD_WIDTH-1:0] mem_word(input logic [WORD_WIDTH-1:0] addr);
        logic [31:0] h;
        h = {16'h0000, addr} * 32'h9e3779b1;
        h = h ^ (h >> 13);
        if (addr[3:1] == 3'b000)
            return '0;
        return h[15:0] ^ h[31:16];
    endfunction

    function automatic logic [WORD_WIDTH-1:0] sign_ext(input logic [WORD_WIDTH-1:0] v,
                                                       input int bits);
        logic [WORD_WIDTH-1:0] r;
        r = v;
        for (int i = bits; i < WORD_WIDTH; i++)
            r[i] = v[bits-1];
        return r;
    endfunction

    function automatic logic [CTRL_WIDTH-1:0] ref_ctrl(input logic [WORD_WIDTH-1:0] w);
        logic [CTRL_WIDTH-1:0]   c;
        logic [OPCODE_WIDTH-1:0] op;
        c = '0;
        op = w[15:12];
        c[CTRL_LD_REG] = !(op inside {OP_BR, OP_JMP, OP_STB, OP_STI, OP_STR, OP_RTI});
        c[CTRL_LD_CC] = op inside {OP_ADD, OP_AND, OP_NOT, OP_SHF, OP_LDB, OP_LDI, OP_LDR,
                                   OP_LEA};
        c[CTRL_MEM_READ] = op inside {OP_LDB, OP_LDI, OP_LDR};
        c[CTRL_MEM_WRITE] = op inside {OP_STB, OP_STI, OP_STR};
        c[CTRL_BRANCH] = (op == OP_BR);
        c[CTRL_JUMP] = op inside {OP_JMP, OP_JSR};
        c[CTRL_TRAP] = (op == OP_TRAP);
        if (op == OP_AND)
            c[CTRL_ALU_LSB +: ALU_WIDTH] = ALU_AND;
        else if (op == OP_NOT)
            c[CTRL_ALU_LSB +: ALU_WIDTH] = ALU_NOT;
        else if (op == OP_SHF)
            c[CTRL_ALU_LSB +: ALU_WIDTH] = ALU_SHF;
        if (w == '0)
            c = '0;
        return c;
    endfunction

    task automatic end_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string what, input logic [WORD_WIDTH-1:0] got,
                              input logic [WORD_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_reg(input string what, input logic [REG_WIDTH-1:0] got,
                             input logic [REG_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_ctrl(input string what, input logic [CTRL_WIDTH-1:0] got,
                              input logic [CTRL_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_issue(input logic [WORD_WIDTH-1:0] addr);
        logic [WORD_WIDTH-1:0] w;
        w = mem_word(addr);
        check_word("issue_pc", issue_pc, addr + WORD_WIDTH'(2));
        check_ctrl("issue_ctrl", issue_ctrl, ref_ctrl(w));
        check_reg("dest", dest, w[11:9]);
        check_reg("src1", src1, w[8:6]);
        check_reg("src2", src2, w[2:0]);
        check_word("imm5", imm5, sign_ext(w, 5));
        check_word("imm4", imm4, w & 16'h000f);
        check_word("offset6", offset6, sign_ext(w, 6));
        check_word("offset9", offset9, sign_ext(w, 9));
        check_word("offset11", offset11, sign_ext(w, 11));
        check_word("trapvect8", trapvect8, (w & 16'h00ff) << 1);
    endtask

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end_with_failure();
    end

    initial
    begin
        seed = 45898;
        held = 0;
        issued = 0;
        cycle = 0;
        mem_wait = 0;
        busy = 1'b0;
        discard = 1'b0;
        issue_due = 1'b0;
        exp_pc = RESET_PC;
        req_addr = '0;
        due_addr = '0;
        reset <= 1'b1;
        mem_resp <= 1'b0;
        mem_rdata <= '0;
        issue_credit <= 1'b0;
        redirect <= 1'b0;
        redirect_pc <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (issued < NUM_INSTR)
        begin
            @(posedge clk);
            if (DUT.u_checker.failures != 0)
            begin
                $display("a bound assertion on the handshakes failed before %0t", $time);
                end_with_failure();
            end
            accept = mem_request && mem_resp;
            kept = accept && !discard && !redirect;
            // downstream side.
            if (issue_valid !== issue_due)
            begin
                $display("issue_valid at %0t does not come one cycle after an accepted response",
                         $time);
                end_with_failure();
            end
            if (issue_valid)
            begin
                check_issue(due_addr);
                held++;
                issued++;
            end
            if (held > ISSUE_CREDITS)
            begin
                $display("more instructions issued than the downstream has credits for");
                end_with_failure();
            end
            issue_due = kept;
            if (kept)
            begin
                due_addr = req_addr;
                exp_pc = exp_pc + WORD_WIDTH'(2);
            end
            // credits are withheld for 20 of every 80 cycles.
            if (held > 0 && (cycle % 80) < 60 && ({$random(seed)} % 3) == 0)
            begin
                issue_credit <= 1'b1;
                held--;
            end
            else
                issue_credit <= 1'b0;
            // memory side.
            if (accept)
            begin
                busy = 1'b0;
                mem_resp <= 1'b0;
            end
            else if (mem_request && !busy)
            begin
                check_word("fetch address", mem_addr, exp_pc);
                in_use = held + int'(issue_due) + 1;
                if (in_use > ISSUE_CREDITS)
                begin
                    $display("a request was made with no free credit at %0t", $time);
                    end_with_failure();
                end
                busy = 1'b1;
                req_addr = mem_addr;
                mem_wait = int'({$random(seed)} % 4);
            end
            if (busy && !accept)
            begin
                if (mem_wait == 0)
                begin
                    mem_resp <= 1'b1;
                    mem_rdata <= mem_word(req_addr);
                end
                else
                    mem_wait--;
            end
            // a redirect kills the outstanding request and moves the pc.
            if (accept)
                discard = 1'b0;
            else if (redirect && mem_request)
                discard = 1'b1;
            if (redirect)
                exp_pc = redirect_pc;
            rnd = $random(seed);
            redirect <= (rnd[4:0] == 5'd0);
            redirect_pc <= {rnd[23:9], 1'b0};
            cycle++;
        end
        @(posedge clk);
        if (DUT.u_checker.failures == 0)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
        begin
            $display("a bound assertion on the handshakes failed in the last cycle");
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

/* verilog/lc3b_ctrl_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_ctrl_rom
    import lc3b_pkg::*;
(
    input  lc3b_instr_u           instr,
    output logic [CTRL_WIDTH-1:0] ctrl_word
);

    always_comb
    begin
        ctrl_word = '0;
        case (instr.r.opcode)
            OP_ADD:
            begin
                ctrl_word[CTRL_LD_REG] = 1'b1;
                ctrl_word[CTRL_LD_CC] = 1'b1;
                ctrl_word[CTRL_ALU_LSB +: ALU_WIDTH] = ALU_ADD;
            end
            OP_AND:
            begin
                ctrl_word[CTRL_LD_REG] = 1'b1;
                ctrl_word[CTRL_LD_CC] = 1'b1;
                ctrl_word[CTRL_ALU_LSB +: ALU_WIDTH] = ALU_AND;
            end
            OP_NOT:
            begin
                ctrl_word[CTRL_LD_REG] = 1'b1;
                ctrl_word[CTRL_LD_CC] = 1'b1;
                ctrl_word[CTRL_ALU_LSB +: ALU_WIDTH] = ALU_NOT;
            end
            OP_SHF:
            begin
                ctrl_word[CTRL_LD_REG] = 1'b1;
                ctrl_word[CTRL_LD_CC] = 1'b1;
                ctrl_word[CTRL_ALU_LSB +: ALU_WIDTH] = ALU_SHF;
            end
            OP_BR:
            begin
                ctrl_word[CTRL_BRANCH] = 1'b1;
            end
            OP_JMP:
            begin
                ctrl_word[CTRL_JUMP] = 1'b1;
            end
            // jsr also writes the link register.
            OP_JSR:
            begin
                ctrl_word[CTRL_JUMP] = 1'b1;
                ctrl_word[CTRL_LD_REG] = 1'b1;
            end
            OP_LDB, OP_LDI, OP_LDR:
            begin
                ctrl_word[CTRL_MEM_READ] = 1'b1;
                ctrl_word[CTRL_LD_REG] = 1'b1;
                ctrl_word[CTRL_LD_CC] = 1'b1;
            end
            OP_LEA:
            begin
                ctrl_word[CTRL_LD_REG] = 1'b1;
                ctrl_word[CTRL_LD_CC] = 1'b1;
            end
            OP_STB, OP_STI, OP_STR:
            begin
                ctrl_word[CTRL_MEM_WRITE] = 1'b1;
            end
            OP_TRAP:
            begin
                ctrl_word[CTRL_TRAP] = 1'b1;
                ctrl_word[CTRL_LD_REG] = 1'b1;
            end
            default:
            begin
                ctrl_word = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/lc3b_fetch_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_fetch_pc
    import lc3b_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_advance,
    input  logic                  redirect,
    input  logic [WORD_WIDTH-1:0] redirect_pc,
    output logic [WORD_WIDTH-1:0] fetch_pc
);

    logic [WORD_WIDTH-1:0] pc_q;
    logic [WORD_WIDTH-1:0] pc_next;

    // redirect wins over the sequential step.
    always_comb
    begin
        if (redirect)
        begin
            pc_next = redirect_pc;
        end
        else if (fetch_advance)
        begin
            pc_next = pc_q + WORD_WIDTH'(2);
        end
        else
        begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc_q <= RESET_PC;
        end
        else
        begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc = pc_q;

endmodule

`default_nettype wire

/* verilog/lc3b_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_frontend
    import lc3b_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_resp,
    input  logic [WORD_WIDTH-1:0] mem_rdata,
    input  logic                  issue_credit,
    input  logic                  redirect,
    input  logic [WORD_WIDTH-1:0] redirect_pc,
    output logic                  mem_request,
    output logic [WORD_WIDTH-1:0] mem_addr,
    output logic                  issue_valid,
    output logic [WORD_WIDTH-1:0] issue_pc,
    output logic [CTRL_WIDTH-1:0] issue_ctrl,
    output logic [REG_WIDTH-1:0]  dest,
    output logic [REG_WIDTH-1:0]  src1,
    output logic [REG_WIDTH-1:0]  src2,
    output logic [WORD_WIDTH-1:0] imm5,
    output logic [WORD_WIDTH-1:0] imm4,
    output logic [WORD_WIDTH-1:0] offset6,
    output logic [WORD_WIDTH-1:0] offset9,
    output logic [WORD_WIDTH-1:0] offset11,
    output logic [WORD_WIDTH-1:0] trapvect8
);

    logic                  fetch_advance;
    logic                  ifid_load;
    logic                  ifid_flush;
    logic [WORD_WIDTH-1:0] fetch_pc;
    logic [CTRL_WIDTH-1:0] ctrl_word;
    lc3b_instr_u           fetch_instr;

    assign fetch_instr = mem_rdata;
    assign mem_addr = fetch_pc;

    lc3b_frontend_ctrl u_ctrl (
        .clk(clk), .reset(reset), .mem_resp(mem_resp), .issue_credit(issue_credit),
        .redirect(redirect), .issue_valid(issue_valid), .mem_request(mem_request),
        .fetch_advance(fetch_advance), .ifid_load(ifid_load), .ifid_flush(ifid_flush)
    );

    lc3b_fetch_pc u_fetch_pc (
        .clk(clk), .reset(reset), .fetch_advance(fetch_advance), .redirect(redirect),
        .redirect_pc(redirect_pc), .fetch_pc(fetch_pc)
    );

    // decode straight off the memory data bus.
    lc3b_ctrl_rom u_ctrl_rom (
        .instr(fetch_instr), .ctrl_word(ctrl_word)
    );

    lc3b_ifid u_ifid (
        .clk(clk), .reset(reset), .ifid_load(ifid_load), .ifid_flush(ifid_flush),
        .instr(fetch_instr), .fetch_pc(fetch_pc), .ctrl_word(ctrl_word),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .imm5(imm5), .imm4(imm4),
        .offset6(offset6), .offset9(offset9), .offset11(offset11),
        .trapvect8(trapvect8), .dest(dest), .src1(src1), .src2(src2),
        .issue_ctrl(issue_ctrl)
    );

endmodule

`default_nettype wire

/* verilog/lc3b_frontend_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_frontend_ctrl
    import lc3b_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic mem_resp,
    input  logic issue_credit,
    input  logic redirect,
    input  logic issue_valid,
    output logic mem_request,
    output logic fetch_advance,
    output logic ifid_load,
    output logic ifid_flush
);

    logic [CREDIT_WIDTH-1:0] credits;
    logic                    discard;
    logic                    accept;
    logic                    drop;
    logic                    launch;

    assign accept = mem_request && mem_resp;

    // a redirect in the response cycle also kills that response.
    assign drop = accept && (discard || redirect);

    // the credit for the new request is reserved at launch.
    assign launch = !mem_request && (credits != '0) && !redirect;

    assign ifid_load = accept && !discard && !redirect;
    assign fetch_advance = ifid_load;

    // clear a word that is still issuing when the redirect arrives.
    assign ifid_flush = drop || (redirect && issue_valid);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_request <= 1'b0;
        end
        else if (accept)
        begin
            mem_request <= 1'b0;
        end
        else if (launch)
        begin
            mem_request <= 1'b1;
        end
    end

    // a redirect can move the pc under a live request; its data is thrown away.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            discard <= 1'b0;
        end
        else if (accept)
        begin
            discard <= 1'b0;
        end
        else if (redirect && mem_request)
        begin
            discard <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credits <= CREDIT_WIDTH'(ISSUE_CREDITS);
        end
        else
        begin
            credits <= credits + CREDIT_WIDTH'(issue_credit) + CREDIT_WIDTH'(drop)
                       - CREDIT_WIDTH'(launch);
        end
    end

endmodule

`default_nettype wire

/* verilog/lc3b_ifid.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_ifid
    import lc3b_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ifid_load,
    input  logic                  ifid_flush,
    input  lc3b_instr_u           instr,
    input  logic [WORD_WIDTH-1:0] fetch_pc,
    input  logic [CTRL_WIDTH-1:0] ctrl_word,
    output logic                  issue_valid,
    output logic [WORD_WIDTH-1:0] issue_pc,
    output logic [WORD_WIDTH-1:0] imm5,
    output logic [WORD_WIDTH-1:0] imm4,
    output logic [WORD_WIDTH-1:0] offset6,
    output logic [WORD_WIDTH-1:0] offset9,
    output logic [WORD_WIDTH-1:0] offset11,
    output logic [WORD_WIDTH-1:0] trapvect8,
    output logic [REG_WIDTH-1:0]  dest,
    output logic [REG_WIDTH-1:0]  src1,
    output logic [REG_WIDTH-1:0]  src2,
    output logic [CTRL_WIDTH-1:0] issue_ctrl
);

    logic [WORD_WIDTH-1:0] word;
    logic                  is_nop;

    assign word = instr;

    // an all-zero word would otherwise decode as a branch.
    assign is_nop = (word == '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            issue_valid <= 1'b0;
            issue_ctrl <= '0;
        end
        else if (ifid_flush)
        begin
            issue_valid <= 1'b0;
            issue_ctrl <= '0;
        end
        else
        begin
            issue_valid <= ifid_load;
            if (ifid_load)
            begin
                issue_ctrl <= is_nop ? '0 : ctrl_word;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ifid_load)
        begin
            issue_pc <= fetch_pc + WORD_WIDTH'(2);
            dest <= instr.r.dest;
            src1 <= instr.r.src1;
            src2 <= instr.r.src2;
            imm5 <= {{(WORD_WIDTH-5){word[4]}}, word[4:0]};
            imm4 <= {{(WORD_WIDTH-4){1'b0}}, word[3:0]};
            offset6 <= {{(WORD_WIDTH-6){word[5]}}, word[5:0]};
            offset9 <= {{(WORD_WIDTH-9){word[8]}}, word[8:0]};
            offset11 <= {{(WORD_WIDTH-11){word[10]}}, word[10:0]};
            // word-aligned trap table index.
            trapvect8 <= {{(WORD_WIDTH-9){1'b0}}, instr.t.trapvect, 1'b0};
        end
    end

endmodule

`default_nettype wire

/* verilog/lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

    // data and address width.
    localparam int WORD_WIDTH = 16;
    localparam int REG_WIDTH = 3;
    localparam int OPCODE_WIDTH = 4;

    localparam logic [WORD_WIDTH-1:0] RESET_PC = 16'h0000;

    // lc-3b opcode values.
    localparam logic [OPCODE_WIDTH-1:0] OP_BR   = 4'b0000;
    localparam logic [OPCODE_WIDTH-1:0] OP_ADD  = 4'b0001;
    localparam logic [OPCODE_WIDTH-1:0] OP_LDB  = 4'b0010;
    localparam logic [OPCODE_WIDTH-1:0] OP_STB  = 4'b0011;
    localparam logic [OPCODE_WIDTH-1:0] OP_JSR  = 4'b0100;
    localparam logic [OPCODE_WIDTH-1:0] OP_AND  = 4'b0101;
    localparam logic [OPCODE_WIDTH-1:0] OP_LDR  = 4'b0110;
    localparam logic [OPCODE_WIDTH-1:0] OP_STR  = 4'b0111;
    localparam logic [OPCODE_WIDTH-1:0] OP_RTI  = 4'b1000;
    localparam logic [OPCODE_WIDTH-1:0] OP_NOT  = 4'b1001;
    localparam logic [OPCODE_WIDTH-1:0] OP_LDI  = 4'b1010;
    localparam logic [OPCODE_WIDTH-1:0] OP_STI  = 4'b1011;
    localparam logic [OPCODE_WIDTH-1:0] OP_JMP  = 4'b1100;
    localparam logic [OPCODE_WIDTH-1:0] OP_SHF  = 4'b1101;
    localparam logic [OPCODE_WIDTH-1:0] OP_LEA  = 4'b1110;
    localparam logic [OPCODE_WIDTH-1:0] OP_TRAP = 4'b1111;

    // control word bit positions.
    localparam int CTRL_WIDTH     = 9;
    localparam int CTRL_LD_REG    = 0;
    localparam int CTRL_LD_CC     = 1;
    localparam int CTRL_MEM_READ  = 2;
    localparam int CTRL_MEM_WRITE = 3;
    localparam int CTRL_BRANCH    = 4;
    localparam int CTRL_JUMP      = 5;
    localparam int CTRL_TRAP      = 6;
    localparam int CTRL_ALU_LSB   = 7;
    localparam int ALU_WIDTH      = 2;

    localparam logic [ALU_WIDTH-1:0] ALU_ADD = 2'd0;
    localparam logic [ALU_WIDTH-1:0] ALU_AND = 2'd1;
    localparam logic [ALU_WIDTH-1:0] ALU_NOT = 2'd2;
    localparam logic [ALU_WIDTH-1:0] ALU_SHF = 2'd3;

    // slots in the downstream buffer.
    localparam int ISSUE_CREDITS = 2;
    localparam int CREDIT_WIDTH  = 2;

    typedef union packed {
        struct packed {
            logic [OPCODE_WIDTH-1:0] opcode;
            logic [REG_WIDTH-1:0]    dest;
            logic [REG_WIDTH-1:0]    src1;
            logic                    imm;
            logic [1:0]              spare;
            logic [REG_WIDTH-1:0]    src2;
        } r;
        struct packed {
            logic [OPCODE_WIDTH-1:0] opcode;
            logic [3:0]              spare;
            logic [7:0]              trapvect;
        } t;
    } lc3b_instr_u;

endpackage

`default_nettype wire

/* vlog.f */
verilog/lc3b_pkg.sv
verilog/lc3b_fetch_pc.sv
verilog/lc3b_ctrl_rom.sv
verilog/lc3b_ifid.sv
verilog/lc3b_frontend_ctrl.sv
verilog/lc3b_frontend.sv
test/lc3b_frontend_checker.sv
test/lc3b_frontend_tb.sv
